// File: rtl/udp_tx_cfg.svh
// compile-time constants of the UDP transmit stage
// include wherever stream widths, FIFO sizes or header constants are needed
`ifndef UDP_TX_CFG_SVH
`define UDP_TX_CFG_SVH

// stream widths
`define UDP_DATA_W      64
`define UDP_KEEP_W      8

// payload FIFO must hold a whole packet while its checksum is built
`define UDP_PAYLOAD_AW  8
`define UDP_MAX_BEATS   200

// per-packet sum and header FIFOs
`define UDP_SUM_AW      3

// protocol constants
`define UDP_PROTO       17
`define UDP_HDR_BYTES   8

// pipeline depth of the pseudo-header fold
`define UDP_FOLD_CYCLES 4

`endif

// File: rtl/udp_tx_pkg.sv
// shared types and checksum arithmetic of the UDP transmit stage
// imported by the checksum stages and the output framer
`default_nettype none

package udp_tx_pkg;

    // pseudo-header fold
    typedef enum logic [1:0] {
        HS_IDLE,
        HS_LOAD,
        HS_FOLD,
        HS_PUSH
    } hdr_sum_state_t;

    // output framing
    typedef enum logic [1:0] {
        FR_IDLE,
        FR_HEADER,
        FR_DATA
    } framer_state_t;

    // 16-bit ones'-complement add with end-around carry
    function automatic logic [15:0] ones_add(input logic [15:0] a, input logic [15:0] b);
        logic [16:0] sum;
        sum = {1'b0, a} + {1'b0, b};
        return sum[15:0] + {15'd0, sum[16]};
    endfunction

endpackage

`default_nettype wire

// File: rtl/sync_fifo.sv
// first-word-fall-through FIFO on a register array
// dout holds the oldest entry whenever empty is low, rd_en pops it
`timescale 1ns/10ps
`default_nettype none

module sync_fifo #(
    parameter int WIDTH = 32,
    parameter int AW    = 3
) (
    input  wire              tx_axis_aclk,
    input  wire              tx_axis_aresetn,
    input  wire              wr_en,
    input  wire  [WIDTH-1:0] din,
    input  wire              rd_en,
    output logic [WIDTH-1:0] dout,
    output logic             empty,
    output logic             full,
    output logic             almost_full
);

    localparam int DEPTH = 2 ** AW;

    logic [WIDTH-1:0] mem [DEPTH];
    logic [AW-1:0]    wr_ptr;
    logic [AW-1:0]    rd_ptr;
    logic [AW:0]      count;

    always_ff @(posedge tx_axis_aclk) begin
        if (wr_en) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge tx_axis_aclk) begin
        if (!tx_axis_aresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + (AW+1)'(wr_en) - (AW+1)'(rd_en);
        end
    end

    // head entry visible without a pop
    assign dout        = mem[rd_ptr];
    assign empty       = (count == '0);
    assign full        = (count == (AW+1)'(DEPTH));
    // two or fewer free slots
    assign almost_full = (count >= (AW+1)'(DEPTH - 2));

    // writers and readers around the FIFO must honour its flags
    assert property (@(posedge tx_axis_aclk) disable iff (!tx_axis_aresetn)
        !(wr_en && full));
    assert property (@(posedge tx_axis_aclk) disable iff (!tx_axis_aresetn)
        !(rd_en && empty));

endmodule

`default_nettype wire

// File: rtl/udp_payload_sum.sv
// byte count and lane checksums of the payload as it streams in
// pushes one {udp length, payload sum} word per packet, a cycle after the last beat
`timescale 1ns/10ps
`default_nettype none
`include "udp_tx_cfg.svh"

module udp_payload_sum (
    input  wire                    tx_axis_aclk,
    input  wire                    tx_axis_aresetn,
    input  wire                    beat_fire,
    input  wire [`UDP_DATA_W-1:0]  tdata,
    input  wire [`UDP_KEEP_W-1:0]  tkeep,
    input  wire                    tlast,
    output logic                   sum_wr_en,
    output logic [31:0]            sum_data
);

    import udp_tx_pkg::*;

    localparam int LANES = `UDP_DATA_W / 16;

    logic [15:0] acc [LANES];
    logic [15:0] acc_next [LANES];
    logic [15:0] lane_total;
    logic [15:0] byte_cnt;
    logic [3:0]  beat_bytes;

    // big-endian words, unkept bytes read as zero
    always_comb begin
        logic [7:0] hi_byte;
        logic [7:0] lo_byte;
        lane_total = '0;
        for (int i = 0; i < LANES; i++) begin
            hi_byte     = tkeep[2*i]   ? tdata[16*i +: 8]   : 8'h00;
            lo_byte     = tkeep[2*i+1] ? tdata[16*i+8 +: 8] : 8'h00;
            acc_next[i] = ones_add(acc[i], {hi_byte, lo_byte});
            lane_total  = ones_add(lane_total, acc_next[i]);
        end
        beat_bytes = 4'($countones(tkeep));
    end

    always_ff @(posedge tx_axis_aclk) begin
        if (!tx_axis_aresetn) begin
            for (int i = 0; i < LANES; i++) begin
                acc[i] <= '0;
            end
            byte_cnt  <= '0;
            sum_wr_en <= 1'b0;
        end else begin
            sum_wr_en <= beat_fire && tlast;
            if (beat_fire) begin
                // last beat closes the packet and restarts the lanes
                for (int i = 0; i < LANES; i++) begin
                    acc[i] <= tlast ? 16'h0000 : acc_next[i];
                end
                byte_cnt <= tlast ? 16'h0000 : byte_cnt + 16'(beat_bytes);
            end
        end
    end

    // udp length counts the 8-byte header too
    always_ff @(posedge tx_axis_aclk) begin
        if (beat_fire && tlast) begin
            sum_data <= {byte_cnt + 16'(beat_bytes) + 16'(`UDP_HDR_BYTES), lane_total};
        end
    end

    // keep fills from lane 0 and only the last beat may be short
    assert property (@(posedge tx_axis_aclk) disable iff (!tx_axis_aresetn)
        beat_fire |-> tkeep[0] && ((tkeep & (tkeep + 1'b1)) == '0) && (tlast || &tkeep));

    // larger packets would not fit in the payload FIFO
    assert property (@(posedge tx_axis_aclk) disable iff (!tx_axis_aresetn)
        beat_fire |-> byte_cnt < 16'(`UDP_MAX_BEATS * `UDP_KEEP_W));

endmodule

`default_nettype wire

// File: rtl/udp_header_sum.sv
// folds the pseudo-header and udp ports into each payload sum
// pops the sum FIFO and pushes {checksum, length}, one packet at a time
`timescale 1ns/10ps
`default_nettype none
`include "udp_tx_cfg.svh"

module udp_header_sum (
    input  wire         tx_axis_aclk,
    input  wire         tx_axis_aresetn,
    input  wire         sum_empty,
    input  wire  [31:0] sum_data,
    input  wire  [31:0] src_ip_addr,
    input  wire  [31:0] dst_ip_addr,
    input  wire  [15:0] udp_src_port,
    input  wire  [15:0] udp_dst_port,
    output logic        sum_rd_en,
    output logic        hdr_wr_en,
    output logic [31:0] hdr_data
);

    import udp_tx_pkg::*;

    localparam int FOLD_CW = $clog2(`UDP_FOLD_CYCLES);

    hdr_sum_state_t     state;
    logic [FOLD_CW-1:0] fold_cnt;
    logic [15:0]        len_q;
    logic [15:0]        pay_q;
    logic [15:0]        s1 [5];
    logic [15:0]        s2 [3];
    logic [15:0]        s3 [2];
    logic [15:0]        s4;

    always_ff @(posedge tx_axis_aclk) begin
        if (!tx_axis_aresetn) begin
            state     <= HS_IDLE;
            fold_cnt  <= '0;
            hdr_wr_en <= 1'b0;
        end else begin
            hdr_wr_en <= 1'b0;
            case (state)
                HS_IDLE: begin
                    if (!sum_empty) begin
                        state <= HS_LOAD;
                    end
                end
                HS_LOAD: begin
                    state    <= HS_FOLD;
                    fold_cnt <= '0;
                end
                HS_FOLD: begin
                    fold_cnt <= fold_cnt + 1'b1;
                    // write pulse lands with the push state
                    if (fold_cnt == FOLD_CW'(`UDP_FOLD_CYCLES - 1)) begin
                        state     <= HS_PUSH;
                        hdr_wr_en <= 1'b1;
                    end
                end
                HS_PUSH: begin
                    state <= HS_IDLE;
                end
                default: begin
                    state <= HS_IDLE;
                end
            endcase
        end
    end

    assign sum_rd_en = (state == HS_LOAD);

    always_ff @(posedge tx_axis_aclk) begin
        if (state == HS_LOAD) begin
            len_q <= sum_data[31:16];
            pay_q <= sum_data[15:0];
        end
    end

    // adder tree, one level per fold cycle
    always_ff @(posedge tx_axis_aclk) begin
        s1[0] <= ones_add(src_ip_addr[31:16], src_ip_addr[15:0]);
        s1[1] <= ones_add(dst_ip_addr[31:16], dst_ip_addr[15:0]);
        s1[2] <= ones_add(16'(`UDP_PROTO), len_q);
        // length appears in both the pseudo-header and the udp header
        s1[3] <= ones_add(len_q, pay_q);
        s1[4] <= ones_add(udp_src_port, udp_dst_port);
        s2[0] <= ones_add(s1[0], s1[1]);
        s2[1] <= ones_add(s1[2], s1[3]);
        s2[2] <= s1[4];
        s3[0] <= ones_add(s2[0], s2[1]);
        s3[1] <= s2[2];
        s4    <= ones_add(s3[0], s3[1]);
    end

    assign hdr_data = {~s4, len_q};

    // addresses and ports are quasi-static and must hold while a packet is folded
    assert property (@(posedge tx_axis_aclk) disable iff (!tx_axis_aresetn)
        state == HS_FOLD |-> $stable(src_ip_addr) && $stable(dst_ip_addr)
            && $stable(udp_src_port) && $stable(udp_dst_port));

endmodule

`default_nettype wire

// File: rtl/udp_tx_framer.sv
// output FSM: one 8-byte udp header beat, then the buffered payload beats
// byte k of a beat sits in tdata[8k+7:8k] and byte 0 goes out first
`timescale 1ns/10ps
`default_nettype none
`include "udp_tx_cfg.svh"

module udp_tx_framer (
    input  wire                                 tx_axis_aclk,
    input  wire                                 tx_axis_aresetn,
    input  wire                                 hdr_empty,
    input  wire  [31:0]                         hdr_data,
    input  wire                                 pay_empty,
    input  wire  [`UDP_DATA_W+`UDP_KEEP_W+1:0]  pay_data,
    input  wire                                 ip_tx_axis_tready,
    input  wire  [15:0]                         udp_src_port,
    input  wire  [15:0]                         udp_dst_port,
    output logic                                hdr_rd_en,
    output logic                                pay_rd_en,
    output logic [`UDP_DATA_W-1:0]              ip_tx_axis_tdata,
    output logic [`UDP_KEEP_W-1:0]              ip_tx_axis_tkeep,
    output logic                                ip_tx_axis_tvalid,
    output logic                                ip_tx_axis_tlast
);

    import udp_tx_pkg::*;

    framer_state_t state;
    logic [15:0]   cks_q;
    logic [15:0]   len_q;
    logic          pay_valid;
    logic          out_fire;

    // payload word is {tdata, tkeep, tvalid, tlast}
    assign pay_valid = !pay_empty && pay_data[1];
    assign out_fire  = ip_tx_axis_tvalid && ip_tx_axis_tready;
    assign hdr_rd_en = (state == FR_IDLE) && !hdr_empty;
    assign pay_rd_en = (state == FR_DATA) && pay_valid && ip_tx_axis_tready;

    always_ff @(posedge tx_axis_aclk) begin
        if (!tx_axis_aresetn) begin
            state <= FR_IDLE;
        end else begin
            case (state)
                FR_IDLE: begin
                    if (!hdr_empty) begin
                        state <= FR_HEADER;
                    end
                end
                FR_HEADER: begin
                    if (ip_tx_axis_tready) begin
                        state <= FR_DATA;
                    end
                end
                FR_DATA: begin
                    if (out_fire && ip_tx_axis_tlast) begin
                        state <= FR_IDLE;
                    end
                end
                default: begin
                    state <= FR_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge tx_axis_aclk) begin
        if (hdr_rd_en) begin
            cks_q <= hdr_data[31:16];
            len_q <= hdr_data[15:0];
        end
    end

    always_comb begin
        ip_tx_axis_tdata  = pay_data[`UDP_KEEP_W+2 +: `UDP_DATA_W];
        ip_tx_axis_tkeep  = pay_data[2 +: `UDP_KEEP_W];
        ip_tx_axis_tlast  = pay_data[0];
        ip_tx_axis_tvalid = (state == FR_DATA) && pay_valid;
        if (state == FR_HEADER) begin
            // ports, length, checksum, each high byte first
            ip_tx_axis_tdata  = {cks_q[7:0], cks_q[15:8], len_q[7:0], len_q[15:8],
                                 udp_dst_port[7:0], udp_dst_port[15:8],
                                 udp_src_port[7:0], udp_src_port[15:8]};
            ip_tx_axis_tkeep  = '1;
            ip_tx_axis_tlast  = 1'b0;
            ip_tx_axis_tvalid = 1'b1;
        end
    end

    // a beat offered downstream is held until taken
    assert property (@(posedge tx_axis_aclk) disable iff (!tx_axis_aresetn)
        ip_tx_axis_tvalid && !ip_tx_axis_tready |=>
            ip_tx_axis_tvalid && $stable(ip_tx_axis_tdata));

endmodule

`default_nettype wire

// File: rtl/udp_tx.sv
// UDP transmit stage for a 64-bit stream
// buffers each payload packet, builds its length and checksum, then sends
// one udp header beat followed by the unchanged payload
`timescale 1ns/10ps
`default_nettype none
`include "udp_tx_cfg.svh"

module udp_tx (
    input  wire                    tx_axis_aclk,
    input  wire                    tx_axis_aresetn,
    input  wire [31:0]             src_ip_addr,
    input  wire [31:0]             dst_ip_addr,
    input  wire [15:0]             udp_src_port,
    input  wire [15:0]             udp_dst_port,
    input  wire [`UDP_DATA_W-1:0]  udp_tx_axis_tdata,
    input  wire [`UDP_KEEP_W-1:0]  udp_tx_axis_tkeep,
    input  wire                    udp_tx_axis_tvalid,
    input  wire                    udp_tx_axis_tlast,
    output logic                   udp_tx_axis_tready,
    output logic [`UDP_DATA_W-1:0] ip_tx_axis_tdata,
    output logic [`UDP_KEEP_W-1:0] ip_tx_axis_tkeep,
    output logic                   ip_tx_axis_tvalid,
    output logic                   ip_tx_axis_tlast,
    input  wire                    ip_tx_axis_tready,
    output logic                   udp_not_empty
);

    localparam int PAY_W = `UDP_DATA_W + `UDP_KEEP_W + 2;

    logic             beat_fire;
    logic [PAY_W-1:0] pay_dout;
    logic             pay_empty;
    logic             pay_full;
    logic             pay_rd_en;
    logic             sum_wr_en;
    logic [31:0]      sum_din;
    logic [31:0]      sum_dout;
    logic             sum_empty;
    logic             sum_afull;
    logic             sum_rd_en;
    logic             hdr_wr_en;
    logic [31:0]      hdr_din;
    logic [31:0]      hdr_dout;
    logic             hdr_empty;
    logic             hdr_afull;
    logic             hdr_rd_en;

    assign udp_tx_axis_tready = !(pay_full || sum_afull || hdr_afull);
    assign beat_fire          = udp_tx_axis_tvalid && udp_tx_axis_tready;
    assign udp_not_empty      = !hdr_empty;

    sync_fifo #(.WIDTH(PAY_W), .AW(`UDP_PAYLOAD_AW)) i_pay_fifo (
        .tx_axis_aclk    (tx_axis_aclk),
        .tx_axis_aresetn (tx_axis_aresetn),
        .wr_en           (beat_fire),
        .din             ({udp_tx_axis_tdata, udp_tx_axis_tkeep,
                           udp_tx_axis_tvalid, udp_tx_axis_tlast}),
        .rd_en           (pay_rd_en),
        .dout            (pay_dout),
        .empty           (pay_empty),
        .full            (pay_full),
        .almost_full     ()
    );

    udp_payload_sum i_payload_sum (
        .tx_axis_aclk    (tx_axis_aclk),
        .tx_axis_aresetn (tx_axis_aresetn),
        .beat_fire       (beat_fire),
        .tdata           (udp_tx_axis_tdata),
        .tkeep           (udp_tx_axis_tkeep),
        .tlast           (udp_tx_axis_tlast),
        .sum_wr_en       (sum_wr_en),
        .sum_data        (sum_din)
    );

    sync_fifo #(.WIDTH(32), .AW(`UDP_SUM_AW)) i_sum_fifo (
        .tx_axis_aclk    (tx_axis_aclk),
        .tx_axis_aresetn (tx_axis_aresetn),
        .wr_en           (sum_wr_en),
        .din             (sum_din),
        .rd_en           (sum_rd_en),
        .dout            (sum_dout),
        .empty           (sum_empty),
        .full            (),
        .almost_full     (sum_afull)
    );

    // fold waits while the header FIFO is nearly full
    udp_header_sum i_header_sum (
        .tx_axis_aclk    (tx_axis_aclk),
        .tx_axis_aresetn (tx_axis_aresetn),
        .sum_empty       (sum_empty || hdr_afull),
        .sum_data        (sum_dout),
        .src_ip_addr     (src_ip_addr),
        .dst_ip_addr     (dst_ip_addr),
        .udp_src_port    (udp_src_port),
        .udp_dst_port    (udp_dst_port),
        .sum_rd_en       (sum_rd_en),
        .hdr_wr_en       (hdr_wr_en),
        .hdr_data        (hdr_din)
    );

    sync_fifo #(.WIDTH(32), .AW(`UDP_SUM_AW)) i_hdr_fifo (
        .tx_axis_aclk    (tx_axis_aclk),
        .tx_axis_aresetn (tx_axis_aresetn),
        .wr_en           (hdr_wr_en),
        .din             (hdr_din),
        .rd_en           (hdr_rd_en),
        .dout            (hdr_dout),
        .empty           (hdr_empty),
        .full            (),
        .almost_full     (hdr_afull)
    );

    udp_tx_framer i_framer (
        .tx_axis_aclk      (tx_axis_aclk),
        .tx_axis_aresetn   (tx_axis_aresetn),
        .hdr_empty         (hdr_empty),
        .hdr_data          (hdr_dout),
        .pay_empty         (pay_empty),
        .pay_data          (pay_dout),
        .ip_tx_axis_tready (ip_tx_axis_tready),
        .udp_src_port      (udp_src_port),
        .udp_dst_port      (udp_dst_port),
        .hdr_rd_en         (hdr_rd_en),
        .pay_rd_en         (pay_rd_en),
        .ip_tx_axis_tdata  (ip_tx_axis_tdata),
        .ip_tx_axis_tkeep  (ip_tx_axis_tkeep),
        .ip_tx_axis_tvalid (ip_tx_axis_tvalid),
        .ip_tx_axis_tlast  (ip_tx_axis_tlast)
    );

endmodule

`default_nettype wire

// File: verif/udp_tx_tb.sv
// testbench of the UDP transmit stage
// sends random payload packets, checks each output header beat, checksum and payload
// against a queue model, then fills the DUT under a stalled output and drains it
`timescale 1ns/10ps
`default_nettype none
`include "udp_tx_cfg.svh"

module udp_tx_tb;

    localparam int CLK_NS      = 4;
    localparam int N_RANDOM    = 24;
    localparam int N_STALL     = 16;
    localparam int WATCHDOG_NS = (N_RANDOM + N_STALL) * 64 * 8 * CLK_NS;
    localparam int MODE_OPEN   = 0;
    localparam int MODE_RANDOM = 1;
    localparam int MODE_HOLD   = 2;

    logic                   tx_axis_aclk = 1'b0;
    logic                   tx_axis_aresetn;
    logic [31:0]            src_ip_addr;
    logic [31:0]            dst_ip_addr;
    logic [15:0]            udp_src_port;
    logic [15:0]            udp_dst_port;
    logic [`UDP_DATA_W-1:0] udp_tx_axis_tdata;
    logic [`UDP_KEEP_W-1:0] udp_tx_axis_tkeep;
    logic                   udp_tx_axis_tvalid;
    logic                   udp_tx_axis_tlast;
    logic                   udp_tx_axis_tready;
    logic [`UDP_DATA_W-1:0] ip_tx_axis_tdata;
    logic [`UDP_KEEP_W-1:0] ip_tx_axis_tkeep;
    logic                   ip_tx_axis_tvalid;
    logic                   ip_tx_axis_tlast;
    logic                   ip_tx_axis_tready;
    logic                   udp_not_empty;

    // model queues, filled when the DUT accepts a beat
    logic [`UDP_DATA_W-1:0] exp_data_q[$];
    logic [`UDP_KEEP_W-1:0] exp_keep_q[$];
    logic                   exp_last_q[$];
    int                     exp_bytes_q[$];
    int                     pkts_in = 0;
    int                     pkts_out = 0;
    int                     beats_in = 0;
    int                     beats_out = 0;
    int                     out_mode = MODE_OPEN;
    logic                   in_packet = 1'b0;
    logic                   saw_tready_low = 1'b0;
    logic [31:0]            csum_acc;

    udp_tx i_dut (.*);

    always #(CLK_NS / 2) tx_axis_aclk = ~tx_axis_aclk;

    task automatic stop_run();
        $display("Result: FAILED");
        $fatal(1, "simulation stopped after the first failure");
    endtask

    task automatic report_error(input string msg);
        $display("ERROR at %0t ns: %s", $time, msg);
        stop_run();
    endtask

    // byte 2k is the high byte of word k
    function automatic logic [15:0] be_word(input logic [63:0] data, input int k);
        return {data[16*k +: 8], data[16*k+8 +: 8]};
    endfunction

    function automatic logic [31:0] beat_word_sum(input logic [63:0] data, input logic [7:0] keep);
        logic [63:0] masked;
        logic [31:0] s;
        masked = data;
        s = '0;
        for (int i = 0; i < 8; i++) begin
            if (!keep[i]) masked[8*i +: 8] = 8'h00;
        end
        for (int k = 0; k < 4; k++) begin
            s = s + 32'(be_word(masked, k));
        end
        return s;
    endfunction

    function automatic logic [15:0] fold16(input logic [31:0] s);
        while (s[31:16] != 16'h0000) begin
            s = 32'(s[15:0]) + 32'(s[31:16]);
        end
        return s[15:0];
    endfunction

    task automatic send_packet(input int n_beats);
        logic [63:0] data;
        logic [7:0]  keep;
        int          nbytes;
        nbytes = 0;
        for (int b = 0; b < n_beats; b++) begin
            data = {$urandom, $urandom};
            keep = (b == n_beats - 1) ? (8'hFF >> $urandom_range(7, 0)) : 8'hFF;
            @(negedge tx_axis_aclk);
            udp_tx_axis_tdata  = data;
            udp_tx_axis_tkeep  = keep;
            udp_tx_axis_tlast  = (b == n_beats - 1);
            udp_tx_axis_tvalid = 1'b1;
            do @(posedge tx_axis_aclk); while (!udp_tx_axis_tready);
            exp_data_q.push_back(data);
            exp_keep_q.push_back(keep);
            exp_last_q.push_back(b == n_beats - 1);
            nbytes += $countones(keep);
            beats_in++;
            // occasional idle cycle inside the packet
            if (b < n_beats - 1 && $urandom_range(3, 0) == 0) begin
                @(negedge tx_axis_aclk);
                udp_tx_axis_tvalid = 1'b0;
            end
        end
        exp_bytes_q.push_back(nbytes);
        pkts_in++;
        @(negedge tx_axis_aclk);
        udp_tx_axis_tvalid = 1'b0;
        udp_tx_axis_tlast  = 1'b0;
    endtask

    task automatic check_header();
        logic [15:0] exp_len;
        assert (exp_bytes_q.size() > 0) else report_error("header beat with no packet pending");
        exp_len = 16'(exp_bytes_q.pop_front() + `UDP_HDR_BYTES);
        assert (ip_tx_axis_tkeep == 8'hFF && !ip_tx_axis_tlast)
            else report_error($sformatf("header tkeep %h tlast %b", ip_tx_axis_tkeep,
                                        ip_tx_axis_tlast));
        assert (be_word(ip_tx_axis_tdata, 0) == udp_src_port &&
                be_word(ip_tx_axis_tdata, 1) == udp_dst_port)
            else report_error($sformatf("header ports %h/%h, expected %h/%h",
                                        be_word(ip_tx_axis_tdata, 0), be_word(ip_tx_axis_tdata, 1),
                                        udp_src_port, udp_dst_port));
        assert (be_word(ip_tx_axis_tdata, 2) == exp_len)
            else report_error($sformatf("header length %0d, expected %0d",
                                        be_word(ip_tx_axis_tdata, 2), exp_len));
        // pseudo-header, then the four header words with the checksum
        csum_acc = 32'(src_ip_addr[31:16]) + 32'(src_ip_addr[15:0]) + 32'(dst_ip_addr[31:16])
                 + 32'(dst_ip_addr[15:0]) + 32'(`UDP_PROTO) + 32'(exp_len);
        for (int k = 0; k < 4; k++) begin
            csum_acc += 32'(be_word(ip_tx_axis_tdata, k));
        end
        in_packet = 1'b1;
    endtask

    task automatic check_payload();
        logic [63:0] data;
        logic [7:0]  keep;
        logic        last;
        assert (exp_data_q.size() > 0) else report_error("payload beat with no beat pending");
        data = exp_data_q.pop_front();
        keep = exp_keep_q.pop_front();
        last = exp_last_q.pop_front();
        assert (ip_tx_axis_tdata == data && ip_tx_axis_tkeep == keep && ip_tx_axis_tlast == last)
            else report_error($sformatf("payload %h/%h/%b, expected %h/%h/%b", ip_tx_axis_tdata,
                                        ip_tx_axis_tkeep, ip_tx_axis_tlast, data, keep, last));
        csum_acc += beat_word_sum(data, keep);
        beats_out++;
        if (last) begin
            assert (fold16(csum_acc) == 16'hFFFF)
                else report_error($sformatf("checksum total %h, expected ffff", fold16(csum_acc)));
            in_packet = 1'b0;
            pkts_out++;
        end
    endtask

    task automatic wait_drained();
        while (pkts_out != pkts_in) @(posedge tx_axis_aclk);
    endtask

    task automatic release_output_after_backpressure();
        int waited;
        waited = 0;
        while (!saw_tready_low && waited < 4000) begin
            @(posedge tx_axis_aclk);
            waited++;
        end
        assert (saw_tready_low) else report_error("input tready never dropped under output stall");
        repeat (20) @(negedge tx_axis_aclk);
        assert (udp_not_empty) else report_error("udp_not_empty low with headers queued");
        @(posedge tx_axis_aclk);
        out_mode = MODE_RANDOM;
    endtask

    // hold the output until the input stalls, then release it and drain
    task automatic stall_phase(input int n_pkts, input int min_beats, input int max_beats);
        saw_tready_low = 1'b0;
        @(posedge tx_axis_aclk);
        out_mode = MODE_HOLD;
        fork
            begin
                for (int i = 0; i < n_pkts; i++) begin
                    send_packet($urandom_range(max_beats, min_beats));
                end
            end
            release_output_after_backpressure();
        join
        wait_drained();
    endtask

    // output back-pressure
    always @(negedge tx_axis_aclk) begin
        case (out_mode)
            MODE_RANDOM: ip_tx_axis_tready = ($urandom_range(3, 0) != 0);
            MODE_HOLD:   ip_tx_axis_tready = 1'b0;
            default:     ip_tx_axis_tready = 1'b1;
        endcase
    end

    always @(posedge tx_axis_aclk) begin
        if (tx_axis_aresetn) begin
            if (out_mode == MODE_HOLD && !udp_tx_axis_tready) saw_tready_low <= 1'b1;
            if (ip_tx_axis_tvalid && ip_tx_axis_tready) begin
                if (in_packet) check_payload();
                else check_header();
            end
        end
    end

    assert property (@(posedge tx_axis_aclk) disable iff (!tx_axis_aresetn)
        ip_tx_axis_tvalid && !ip_tx_axis_tready |=> ip_tx_axis_tvalid
            && $stable(ip_tx_axis_tdata) && $stable(ip_tx_axis_tkeep) && $stable(ip_tx_axis_tlast))
        else report_error("output beat changed while stalled");

    // payload FIFO holds 2**UDP_PAYLOAD_AW beats
    assert property (@(posedge tx_axis_aclk) disable iff (!tx_axis_aresetn)
        (beats_in - beats_out) <= (2 ** `UDP_PAYLOAD_AW))
        else report_error("more beats accepted than the payload FIFO can hold");

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the DUT did not deliver all packets within %0d ns", WATCHDOG_NS);
        stop_run();
    end

    initial begin
        void'($urandom(32'hd1535533));
        tx_axis_aresetn    = 1'b0;
        src_ip_addr        = $urandom;
        dst_ip_addr        = $urandom;
        udp_src_port       = 16'($urandom);
        udp_dst_port       = 16'($urandom);
        udp_tx_axis_tdata  = '0;
        udp_tx_axis_tkeep  = '0;
        udp_tx_axis_tvalid = 1'b0;
        udp_tx_axis_tlast  = 1'b0;
        ip_tx_axis_tready  = 1'b1;
        repeat (4) @(posedge tx_axis_aclk);
        @(negedge tx_axis_aclk);
        tx_axis_aresetn = 1'b1;
        repeat (3) @(posedge tx_axis_aclk);
        assert (!ip_tx_axis_tvalid && !udp_not_empty && udp_tx_axis_tready)
            else report_error("idle state after reset is wrong");

        out_mode = MODE_RANDOM;
        for (int i = 0; i < N_RANDOM; i++) begin
            send_packet($urandom_range(32, 1));
        end
        wait_drained();

        // addresses change only while the DUT is empty
        @(negedge tx_axis_aclk);
        src_ip_addr  = $urandom;
        dst_ip_addr  = $urandom;
        udp_src_port = 16'($urandom);
        udp_dst_port = 16'($urandom);

        // short packets fill the sum and header FIFOs first
        stall_phase(N_STALL / 2, 2, 4);
        // long packets fill the payload FIFO first
        stall_phase(N_STALL / 2, 40, 64);

        @(negedge tx_axis_aclk);
        assert (!udp_not_empty && !ip_tx_axis_tvalid && udp_tx_axis_tready)
            else report_error("DUT not idle after all packets drained");
        assert (exp_data_q.size() == 0 && exp_bytes_q.size() == 0)
            else report_error("model queues not empty at the end");
        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
+incdir+rtl
rtl/udp_tx_pkg.sv
rtl/sync_fifo.sv
rtl/udp_payload_sum.sv
rtl/udp_header_sum.sv
rtl/udp_tx_framer.sv
rtl/udp_tx.sv
verif/udp_tx_tb.sv

// File: Bender.yml
package:
  name: udp_tx

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/udp_tx_pkg.sv
      - rtl/sync_fifo.sv
      - rtl/udp_payload_sum.sv
      - rtl/udp_header_sum.sv
      - rtl/udp_tx_framer.sv
      - rtl/udp_tx.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - verif/udp_tx_tb.sv
